// File: verilog/vector_dot_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared geometry for the backprop element-wise product unit
//////////////////////////////////////////////////////////////////////

package vector_dot_pkg;

    // Cells per vector
    localparam int vd_vector_len = 5;

    // Operand cell widths, signed fixed point
    localparam int vd_a_width = 8;
    localparam int vd_b_width = 8;

    // Result cell width after shift and clamp
    localparam int vd_result_width = 10;

    // Fraction bits dropped from each full product
    localparam int vd_fraction_width = 2;

    // Multiplier lanes working in parallel
    localparam int vd_tiling = 1;

    //////////////////////////////////////////////////////////////////////
    // Tile count helper
    //////////////////////////////////////////////////////////////////////

    // Ceiling of vector_len over tiling
    // One tile per busy cycle, last tile may be partly masked
    function automatic int vd_tile_count(
        input int vector_len,
        input int tiling
    );
        int tiles;
        tiles = (vector_len + tiling - 1) / tiling;
        // Degenerate geometry still needs one tile
        if (tiles < 1) begin
            tiles = 1;
        end
        return tiles;
    endfunction

endpackage

`default_nettype wire

// File: verilog/fixed_mult.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Signed fixed-point multiplier cell
//////////////////////////////////////////////////////////////////////

module fixed_mult #(
    parameter int A_WIDTH        = 8,
    parameter int B_WIDTH        = 8,
    parameter int RESULT_WIDTH   = 10,
    parameter int FRACTION_WIDTH = 2
) (
    input  wire logic signed [A_WIDTH-1:0]      a,
    input  wire logic signed [B_WIDTH-1:0]      b,
    output logic signed [RESULT_WIDTH-1:0]      product,
    output logic                                overflow
);

    // Full product width, no bits lost
    localparam int PROD_WIDTH = A_WIDTH + B_WIDTH;

    // Working width wide enough for both product and result
    localparam int EXT_WIDTH = (PROD_WIDTH > RESULT_WIDTH) ? PROD_WIDTH : RESULT_WIDTH;

    // Bits above the result sign bit, plus the sign bit itself
    localparam int HIGH_WIDTH = EXT_WIDTH - RESULT_WIDTH + 1;

    // Clamp limits of the result cell
    localparam logic signed [RESULT_WIDTH-1:0] RESULT_MAX =
        {1'b0, {(RESULT_WIDTH-1){1'b1}}};
    localparam logic signed [RESULT_WIDTH-1:0] RESULT_MIN =
        {1'b1, {(RESULT_WIDTH-1){1'b0}}};

    logic signed [PROD_WIDTH-1:0] full_product;
    logic signed [PROD_WIDTH-1:0] shifted_product;
    logic signed [EXT_WIDTH-1:0]  shifted_ext;
    logic        [HIGH_WIDTH-1:0] high_bits;
    logic                         sign_bit;

    //////////////////////////////////////////////////////////////////////
    // Multiply and drop fraction bits
    //////////////////////////////////////////////////////////////////////

    // Both operands signed, so the product is sign extended
    assign full_product = a * b;

    // Arithmetic shift, truncates toward minus infinity
    assign shifted_product = full_product >>> FRACTION_WIDTH;

    // Sign extend into the working width
    assign shifted_ext = shifted_product;

    //////////////////////////////////////////////////////////////////////
    // Saturation
    //////////////////////////////////////////////////////////////////////

    // Fits only if all high bits repeat the sign
    assign high_bits = shifted_ext[EXT_WIDTH-1:RESULT_WIDTH-1];
    assign sign_bit  = shifted_ext[EXT_WIDTH-1];

    always_comb begin
        overflow = (high_bits != {HIGH_WIDTH{1'b0}}) &&
                   (high_bits != {HIGH_WIDTH{1'b1}});
        if (!overflow) begin
            product = shifted_ext[RESULT_WIDTH-1:0];
        end else if (sign_bit) begin
            // Too negative
            product = RESULT_MIN;
        end else begin
            // Too positive
            product = RESULT_MAX;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vector_dot.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Element-wise fixed-point vector product, tiled over lanes
//////////////////////////////////////////////////////////////////////

module vector_dot #(
    parameter int VECTOR_LEN        = 5,
    parameter int A_CELL_WIDTH      = 8,
    parameter int B_CELL_WIDTH      = 8,
    parameter int RESULT_CELL_WIDTH = 10,
    parameter int FRACTION_WIDTH    = 2,
    parameter int TILING            = 1
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  start,
    input  wire logic [VECTOR_LEN*A_CELL_WIDTH-1:0]    a,
    input  wire logic [VECTOR_LEN*B_CELL_WIDTH-1:0]    b,
    output logic [VECTOR_LEN*RESULT_CELL_WIDTH-1:0]    result,
    output logic                                       valid,
    output logic                                       error
);

    import vector_dot_pkg::*;

    // Tiles per vector
    localparam int TILES = vd_tile_count(VECTOR_LEN, TILING);

    // Cells covered by all tiles, includes masked tail
    localparam int PAD_LEN = TILES * TILING;

    localparam int CNT_WIDTH = (TILES > 1) ? $clog2(TILES) : 1;
    localparam int IDX_WIDTH = $clog2(PAD_LEN + 1);

    // Padded operand widths
    localparam int A_PAD_WIDTH = PAD_LEN * A_CELL_WIDTH;
    localparam int B_PAD_WIDTH = PAD_LEN * B_CELL_WIDTH;

    // Operand registers, zero padded up to a whole tile
    logic [A_PAD_WIDTH-1:0] a_reg;
    logic [B_PAD_WIDTH-1:0] b_reg;

    // Control state
    logic                 busy;
    logic [CNT_WIDTH-1:0] tile_cnt;
    logic                 last_tile;
    logic                 accept;
    logic                 err_acc;
    logic                 valid_reg;

    // Result register, held until the next capture
    logic [VECTOR_LEN*RESULT_CELL_WIDTH-1:0] result_reg;

    // Per-lane signals
    logic        [IDX_WIDTH-1:0]         lane_idx     [TILING];
    logic signed [A_CELL_WIDTH-1:0]      lane_a       [TILING];
    logic signed [B_CELL_WIDTH-1:0]      lane_b       [TILING];
    logic signed [RESULT_CELL_WIDTH-1:0] lane_product [TILING];
    logic        [TILING-1:0]            lane_ovf;
    logic        [TILING-1:0]            lane_valid;
    logic                                any_ovf;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    // Start only counts while idle
    assign accept    = start && !busy;
    assign last_tile = (tile_cnt == CNT_WIDTH'(TILES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            tile_cnt  <= '0;
            err_acc   <= 1'b0;
            valid_reg <= 1'b0;
        end else begin
            // Valid is a single-cycle pulse
            valid_reg <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                tile_cnt <= '0;
                // New vector, fresh error
                err_acc  <= 1'b0;
            end else if (busy) begin
                // Sticky overflow across tiles
                err_acc <= err_acc | any_ovf;
                if (last_tile) begin
                    busy      <= 1'b0;
                    tile_cnt  <= '0;
                    valid_reg <= 1'b1;
                end else begin
                    tile_cnt <= tile_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operand capture and result assembly
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            // Zero extend, tail cells feed masked lanes only
            a_reg <= A_PAD_WIDTH'(a);
            b_reg <= B_PAD_WIDTH'(b);
        end
        if (busy) begin
            // Write this tile's lanes at their cell offset
            for (int lane = 0; lane < TILING; lane++) begin
                if (lane_valid[lane]) begin
                    result_reg[lane_idx[lane]*RESULT_CELL_WIDTH +: RESULT_CELL_WIDTH] <=
                        lane_product[lane];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Multiplier lanes
    //////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < TILING; l++) begin : gen_lane
        // Cell handled by this lane in the current tile
        assign lane_idx[l]   = IDX_WIDTH'(tile_cnt * TILING + l);
        assign lane_valid[l] = (lane_idx[l] < IDX_WIDTH'(VECTOR_LEN));

        // Steer the cell pair into the lane
        assign lane_a[l] = a_reg[lane_idx[l]*A_CELL_WIDTH +: A_CELL_WIDTH];
        assign lane_b[l] = b_reg[lane_idx[l]*B_CELL_WIDTH +: B_CELL_WIDTH];

        fixed_mult #(
            .A_WIDTH        (A_CELL_WIDTH),
            .B_WIDTH        (B_CELL_WIDTH),
            .RESULT_WIDTH   (RESULT_CELL_WIDTH),
            .FRACTION_WIDTH (FRACTION_WIDTH)
        ) fixed_mult_inst (
            .a        (lane_a[l]),
            .b        (lane_b[l]),
            .product  (lane_product[l]),
            .overflow (lane_ovf[l])
        );
    end

    // Masked lanes never raise error
    assign any_ovf = |(lane_ovf & lane_valid);

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    assign result = result_reg;
    assign valid  = valid_reg;

    // Error only shown alongside valid
    assign error  = valid_reg & err_acc;

endmodule

`default_nettype wire

// File: verilog/backprop_dot_top.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Top level of the backprop product block
//////////////////////////////////////////////////////////////////////

module backprop_dot_top #(
    // Geometry defaults from the shared package
    parameter int VECTOR_LEN        = vector_dot_pkg::vd_vector_len,
    parameter int A_CELL_WIDTH      = vector_dot_pkg::vd_a_width,
    parameter int B_CELL_WIDTH      = vector_dot_pkg::vd_b_width,
    parameter int RESULT_CELL_WIDTH = vector_dot_pkg::vd_result_width,
    parameter int FRACTION_WIDTH    = vector_dot_pkg::vd_fraction_width,
    parameter int TILING            = vector_dot_pkg::vd_tiling
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,

    // One-cycle request with packed operands, cell 0 low
    input  wire logic                                  start,
    input  wire logic [VECTOR_LEN*A_CELL_WIDTH-1:0]    a,
    input  wire logic [VECTOR_LEN*B_CELL_WIDTH-1:0]    b,

    // Packed products, held until the next start
    output logic [VECTOR_LEN*RESULT_CELL_WIDTH-1:0]    result,

    // Done pulse, saturation flag with it
    output logic                                       valid,
    output logic                                       error
);

    // Internal nets between the pins and the core
    logic [VECTOR_LEN*RESULT_CELL_WIDTH-1:0] dot_result;
    logic                                    dot_valid;
    logic                                    dot_error;

    //////////////////////////////////////////////////////////////////////
    // Product core
    //////////////////////////////////////////////////////////////////////

    // Geometry passed straight down
    vector_dot #(
        .VECTOR_LEN        (VECTOR_LEN),
        .A_CELL_WIDTH      (A_CELL_WIDTH),
        .B_CELL_WIDTH      (B_CELL_WIDTH),
        .RESULT_CELL_WIDTH (RESULT_CELL_WIDTH),
        .FRACTION_WIDTH    (FRACTION_WIDTH),
        .TILING            (TILING)
    ) vector_dot_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .result (dot_result),
        .valid  (dot_valid),
        .error  (dot_error)
    );

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // No added latency
    assign result = dot_result;
    assign valid  = dot_valid;
    assign error  = dot_error;

endmodule

`default_nettype wire

// File: test/vector_dot_sva.sv
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Timing and reset properties of the product unit
//////////////////////////////////////////////////////////////////////

module vector_dot_sva #(
    parameter int VECTOR_LEN = 5,
    parameter int TILING     = 1
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    input  wire logic busy,
    input  wire logic valid,
    input  wire logic error
);

    import vector_dot_pkg::*;

    // Busy cycles per vector
    localparam int TILES = vd_tile_count(VECTOR_LEN, TILING);

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
        else $error("valid stayed high for two cycles");

    // Valid on the tile count plus one edge after capture
    assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> ##(TILES + 1) valid)
        else $error("valid missing after accepted start");

    // Quiet outputs while in reset
    assert property (@(posedge clk) !rst_n |=> (!valid && !error))
        else $error("valid or error high during reset");

endmodule

// Attached to every vector_dot with the target's geometry
bind vector_dot vector_dot_sva #(
    .VECTOR_LEN (VECTOR_LEN),
    .TILING     (TILING)
) vector_dot_sva_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .valid (valid),
    .error (error)
);

`default_nettype wire

// File: test/tb_vector_dot.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vector_dot;

    import vector_dot_pkg::*;

    // Geometry, two lanes so the last tile has a masked lane
    localparam int VL        = vd_vector_len;
    localparam int AW        = vd_a_width;
    localparam int BW        = vd_b_width;
    localparam int RW        = vd_result_width;
    localparam int FW        = vd_fraction_width;
    localparam int TB_TILING = 2;
    localparam int TILES     = vd_tile_count(VL, TB_TILING);

    localparam int A_TOTAL = VL * AW;
    localparam int B_TOTAL = VL * BW;
    localparam int R_TOTAL = VL * RW;

    // Vectors issued over the whole run, ignored start included
    localparam int NUM_VECTORS    = 25;
    localparam int TIMEOUT_CYCLES = 200 + 10 * NUM_VECTORS;
    localparam int WAIT_LIMIT     = TILES + 8;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [A_TOTAL-1:0] a_in;
    logic [B_TOTAL-1:0] b_in;
    logic [R_TOTAL-1:0] result;
    logic               valid;
    logic               error;

    logic [31:0]        lcg_state;
    logic [R_TOTAL-1:0] last_result;
    int                 error_count;
    int                 errors_at_test_start;
    int                 pass_count;
    int                 fail_count;
    int                 cycle_count;

    backprop_dot_top #(
        .VECTOR_LEN        (VL),
        .A_CELL_WIDTH      (AW),
        .B_CELL_WIDTH      (BW),
        .RESULT_CELL_WIDTH (RW),
        .FRACTION_WIDTH    (FW),
        .TILING            (TB_TILING)
    ) backprop_dot_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a      (a_in),
        .b      (b_in),
        .result (result),
        .valid  (valid),
        .error  (error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit counted in clock cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sixteen upper LCG bits per step, low bits are weak
    task automatic random_operand(output logic [63:0] value);
        for (int k = 0; k < 4; k++) begin
            lcg_state = lcg_next(lcg_state);
            value[k*16 +: 16] = lcg_state[31:16];
        end
    endtask

    // Per cell: full product, floor shift, clamp, overflow OR
    function automatic void reference_vector(
        input  logic [A_TOTAL-1:0] av,
        input  logic [B_TOTAL-1:0] bv,
        output logic [R_TOTAL-1:0] res,
        output logic               err
    );
        int prod;
        int shifted;
        int hi;
        int lo;
        hi  = (1 << (RW - 1)) - 1;
        lo  = -(1 << (RW - 1));
        err = 1'b0;
        res = '0;
        for (int i = 0; i < VL; i++) begin
            prod    = int'($signed(av[i*AW +: AW])) * int'($signed(bv[i*BW +: BW]));
            shifted = prod >>> FW;
            if (shifted > hi) begin
                shifted = hi;
                err     = 1'b1;
            end else if (shifted < lo) begin
                shifted = lo;
                err     = 1'b1;
            end
            res[i*RW +: RW] = RW'(shifted);
        end
    endfunction

    task automatic check_value(
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        assert (actual === expected) else begin
            $display("mismatch at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic mark_test_start;
        errors_at_test_start = error_count;
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_at_test_start) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    // One-cycle start, returns just after the capture edge
    task automatic send_vector(input logic [A_TOTAL-1:0] av, input logic [B_TOTAL-1:0] bv);
        a_in  <= av;
        b_in  <= bv;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // Edges from the capture edge to the one sampling valid
    task automatic wait_for_valid(output int latency);
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!valid && latency < WAIT_LIMIT);
        assert (valid) else begin
            $display("no valid pulse within %0d cycles after start", WAIT_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_vector(input logic [A_TOTAL-1:0] av, input logic [B_TOTAL-1:0] bv);
        logic [R_TOTAL-1:0] exp_result;
        logic               exp_error;
        int                 latency;
        reference_vector(av, bv, exp_result, exp_error);
        send_vector(av, bv);
        wait_for_valid(latency);
        check_value("valid latency", TILES + 1, latency);
        check_value("result", exp_result, result);
        check_value("error", exp_error, error);
        last_result = exp_result;
    endtask

    // Result stays put while idle
    task automatic watch_result_hold(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_value("valid", 1'b0, valid);
            check_value("result", last_result, result);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Busy start ignored, start in the valid cycle accepted
    //////////////////////////////////////////////////////////////////////

    task automatic run_back_to_back;
        logic [63:0]        p_a;
        logic [63:0]        p_b;
        logic [63:0]        q_a;
        logic [63:0]        r_a;
        logic [63:0]        r_b;
        logic [R_TOTAL-1:0] p_result;
        logic [R_TOTAL-1:0] r_result;
        logic               p_error;
        logic               r_error;
        int                 latency;
        random_operand(p_a);
        random_operand(p_b);
        random_operand(q_a);
        random_operand(r_a);
        random_operand(r_b);
        reference_vector(p_a[A_TOTAL-1:0], p_b[B_TOTAL-1:0], p_result, p_error);
        reference_vector(r_a[A_TOTAL-1:0], r_b[B_TOTAL-1:0], r_result, r_error);
        // Capture P
        a_in  <= p_a[A_TOTAL-1:0];
        b_in  <= p_b[B_TOTAL-1:0];
        start <= 1'b1;
        @(posedge clk);
        // Q arrives while busy
        a_in <= q_a[A_TOTAL-1:0];
        @(posedge clk);
        start <= 1'b0;
        check_value("valid", 1'b0, valid);
        repeat (TILES - 1) begin
            @(posedge clk);
            check_value("valid", 1'b0, valid);
        end
        // Start lands in the valid cycle of P
        a_in  <= r_a[A_TOTAL-1:0];
        b_in  <= r_b[B_TOTAL-1:0];
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        check_value("valid", 1'b1, valid);
        check_value("result", p_result, result);
        check_value("error", p_error, error);
        wait_for_valid(latency);
        check_value("valid latency", TILES + 1, latency);
        check_value("result", r_result, result);
        check_value("error", r_error, error);
        last_result = r_result;
        // No stray pulse from the ignored start
        watch_result_hold(TILES + 2);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [63:0] rand_a;
        logic [63:0] rand_b;
        rst_n                = 1'b0;
        start                = 1'b0;
        a_in                 = '0;
        b_in                 = '0;
        lcg_state            = 32'he9f;
        last_result          = '0;
        error_count          = 0;
        errors_at_test_start = 0;
        pass_count           = 0;
        fail_count           = 0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        mark_test_start();
        repeat (6) begin
            @(posedge clk);
            check_value("valid", 1'b0, valid);
            check_value("error", 1'b0, error);
        end
        report_test("reset");

        // Cells 3*4, -5*6, 10*-3, 7*8, -2*5
        mark_test_start();
        run_vector({-8'sd2, 8'sd7, 8'sd10, -8'sd5, 8'sd3},
                   {8'sd5, 8'sd8, -8'sd3, 8'sd6, 8'sd4});
        report_test("in-range values");

        // Cells 127*-128, -128*-128, 100*100, 5*5, -128*127
        mark_test_start();
        run_vector({8'h80, 8'sd5, 8'sd100, 8'h80, 8'sd127},
                   {8'sd127, 8'sd5, 8'sd100, 8'h80, 8'h80});
        check_value("error", 1'b1, error);
        report_test("saturation");

        mark_test_start();
        watch_result_hold(6);
        report_test("result hold");

        mark_test_start();
        repeat (20) begin
            random_operand(rand_a);
            random_operand(rand_b);
            run_vector(rand_a[A_TOTAL-1:0], rand_b[B_TOTAL-1:0]);
        end
        report_test("random vectors");

        mark_test_start();
        run_back_to_back();
        report_test("busy and back-to-back starts");

        $display("tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/vector_dot_pkg.sv
verilog/fixed_mult.sv
verilog/vector_dot.sv
verilog/backprop_dot_top.sv
test/vector_dot_sva.sv
test/tb_vector_dot.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vector_dot testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_vector_dot
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_vector_dot \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG_FILE"; then
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG_FILE"; then
    echo "simulation log holds no final verdict"
    exit 1
fi

exit 0
